// File: src/quant_defines.svh
`ifndef QUANT_DEFINES_SVH
`define QUANT_DEFINES_SVH

////////////////////////////////////////////////////////////
// lane geometry
////////////////////////////////////////////////////////////

// pixels per pe (2) times array columns (4)
`define QO_LANES_PER_CH 8
`define QO_CHANNELS 2
`define QO_LANES (`QO_CHANNELS * `QO_LANES_PER_CH)

////////////////////////////////////////////////////////////
// data widths
////////////////////////////////////////////////////////////

`define QO_ACC_W 40
`define QO_BIAS_W 32
`define QO_SCALE_W 8
`define QO_Q_W 8
`define QO_ROW_CNT_W 8

// packed vector widths
`define QO_ACC_VEC_W (`QO_LANES * `QO_ACC_W)
`define QO_Q_VEC_W (`QO_LANES * `QO_Q_W)
`define QO_SCALE_SET_W (`QO_CHANNELS * `QO_SCALE_W)
`define QO_BIAS_SET_W (`QO_CHANNELS * `QO_BIAS_W)

// bias add and quantize registers still holding data after the last row
`define QO_FLUSH 2

`endif

// File: src/quant_pkg.sv
package quant_pkg;

  ////////////////////////////////////////////////////////////
  // tile mode
  ////////////////////////////////////////////////////////////

  // MODE_88: one channel with 16-bit weights, upper lanes unused
  // MODE_18: two channels with 8-bit weights
  typedef enum logic {
    MODE_88 = 1'b0,
    MODE_18 = 1'b1
  } quant_mode_e;

  ////////////////////////////////////////////////////////////
  // drain controller states
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_DRAIN = 2'd1,
    ST_FLUSH = 2'd2,
    ST_DONE  = 2'd3
  } drain_state_e;

endpackage

// File: src/drain_counter.sv
`timescale 1ns/1ps
`include "quant_defines.svh"

module drain_counter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load,
  input  logic [`QO_ROW_CNT_W-1:0] value,
  input  logic                     dec,
  output logic                     zero_next
);

  logic [`QO_ROW_CNT_W-1:0] count;

  // load takes priority over a decrement in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= value;
    end else if (dec) begin
      count <= count - 1'b1;
    end
  end

  // final decrement happens on this edge
  assign zero_next = dec && (count == `QO_ROW_CNT_W'(1));

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // controller must stop decrementing once the count has run out
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    (dec && !load) |-> (count != '0)
  ) else $error("drain_counter: dec while count is zero");

endmodule

// File: src/drain_ctrl_fsm.sv
`timescale 1ns/1ps
`include "quant_defines.svh"

module drain_ctrl_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  quant_pkg::quant_mode_e     mode,
  input  logic [`QO_SCALE_SET_W-1:0] scale_set,
  input  logic [`QO_BIAS_SET_W-1:0]  bias_set,
  input  logic [`QO_ROW_CNT_W-1:0]   row_count,
  input  logic                       acc_valid,
  input  logic                       cnt_zero,
  output logic                       cnt_load,
  output logic [`QO_ROW_CNT_W-1:0]   cnt_value,
  output logic                       cnt_dec,
  output logic                       row_take,
  output quant_pkg::quant_mode_e     mode_q,
  output logic [`QO_SCALE_SET_W-1:0] scale_q,
  output logic [`QO_BIAS_SET_W-1:0]  bias_q,
  output logic                       busy,
  output logic                       done
);
  import quant_pkg::*;

  drain_state_e state;
  drain_state_e state_next;
  logic         start_take;

  assign start_take = start && (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // tile settings, held until the next accepted start
  always_ff @(posedge clk) begin
    if (start_take) begin
      mode_q  <= mode;
      scale_q <= scale_set;
      bias_q  <= bias_set;
    end
  end

  // rows only count while draining
  assign row_take = acc_valid && (state == ST_DRAIN);

  ////////////////////////////////////////////////////////////
  // next state and counter control
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    cnt_load   = 1'b0;
    cnt_value  = row_count;
    cnt_dec    = 1'b0;
    case (state)
      ST_IDLE: begin
        if (start_take) begin
          cnt_load   = 1'b1;
          state_next = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        cnt_dec = row_take;
        // last row taken, count out the pipeline next
        if (cnt_zero) begin
          cnt_load   = 1'b1;
          cnt_value  = `QO_ROW_CNT_W'(`QO_FLUSH);
          state_next = ST_FLUSH;
        end
      end
      ST_FLUSH: begin
        cnt_dec = 1'b1;
        if (cnt_zero) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  assign busy = (state != ST_IDLE);
  assign done = (state == ST_DONE);

  // one done per tile
  a_done_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> !done
  ) else $error("drain_ctrl_fsm: done high for two cycles");

endmodule

// File: src/bias_add_stage.sv
`timescale 1ns/1ps
`include "quant_defines.svh"

module bias_add_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      take,
  input  logic [`QO_ACC_VEC_W-1:0]  acc_vector,
  input  logic [`QO_BIAS_SET_W-1:0] bias_q,
  output logic [`QO_ACC_VEC_W-1:0]  sum_vector,
  output logic                      sum_valid
);

  logic [`QO_ACC_W-1:0]     bias_ext [`QO_CHANNELS];
  logic [`QO_ACC_VEC_W-1:0] sum_next;

  genvar ch;
  genvar ln;

  ////////////////////////////////////////////////////////////
  // per channel bias, sign-extended to accumulator width
  ////////////////////////////////////////////////////////////

  generate
    for (ch = 0; ch < `QO_CHANNELS; ch++) begin : g_bias
      logic [`QO_BIAS_W-1:0] bias_word;
      assign bias_word = bias_q[ch*`QO_BIAS_W +: `QO_BIAS_W];
      assign bias_ext[ch] = {{(`QO_ACC_W - `QO_BIAS_W){bias_word[`QO_BIAS_W-1]}}, bias_word};
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // lane adders
  ////////////////////////////////////////////////////////////

  // lanes are grouped by channel, lower channel first
  // 40-bit sum wraps on overflow
  generate
    for (ln = 0; ln < `QO_LANES; ln++) begin : g_lane
      assign sum_next[ln*`QO_ACC_W +: `QO_ACC_W] =
        acc_vector[ln*`QO_ACC_W +: `QO_ACC_W] + bias_ext[ln / `QO_LANES_PER_CH];
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (take) begin
      sum_vector <= sum_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= take;
    end
  end

endmodule

// File: src/relu_scale_quant.sv
`timescale 1ns/1ps
`include "quant_defines.svh"

module relu_scale_quant (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       sum_valid,
  input  logic [`QO_ACC_VEC_W-1:0]   sum_vector,
  input  quant_pkg::quant_mode_e     mode,
  input  logic [`QO_SCALE_SET_W-1:0] scale_q,
  output logic [`QO_Q_VEC_W-1:0]     q_vector,
  output logic                       q_valid
);
  import quant_pkg::*;

  // largest value that fits in one output lane
  localparam logic [`QO_ACC_W-1:0] Q_MAX = {{(`QO_ACC_W - `QO_Q_W){1'b0}}, {`QO_Q_W{1'b1}}};
  // first bit of the upper channel in q_vector
  localparam int Q_HI_LSB = `QO_LANES_PER_CH * `QO_Q_W;

  logic [`QO_SCALE_W-1:0] scale_lo;
  logic [`QO_SCALE_W-1:0] scale_hi;
  logic [`QO_Q_VEC_W-1:0] q_next;

  genvar ln;

  assign scale_lo = scale_q[0 +: `QO_SCALE_W];
  assign scale_hi = scale_q[`QO_SCALE_W +: `QO_SCALE_W];

  ////////////////////////////////////////////////////////////
  // lane rule
  ////////////////////////////////////////////////////////////

  // relu, truncating shift, clamp to unsigned 8 bits
  function automatic logic [`QO_Q_W-1:0] quant_lane(
    input logic [`QO_ACC_W-1:0]   sum,
    input logic [`QO_SCALE_W-1:0] scale
  );
    logic [`QO_ACC_W-1:0] shifted;
    shifted = sum >> scale;
    if (sum[`QO_ACC_W-1]) begin
      return '0;
    end else if (shifted > Q_MAX) begin
      return '1;
    end
    return shifted[`QO_Q_W-1:0];
  endfunction

  generate
    // lower channel uses scale byte 0 in both modes
    for (ln = 0; ln < `QO_LANES_PER_CH; ln++) begin : g_low
      assign q_next[ln*`QO_Q_W +: `QO_Q_W] =
        quant_lane(sum_vector[ln*`QO_ACC_W +: `QO_ACC_W], scale_lo);
    end
    // upper channel only exists in MODE_18
    for (ln = `QO_LANES_PER_CH; ln < `QO_LANES; ln++) begin : g_high
      assign q_next[ln*`QO_Q_W +: `QO_Q_W] = (mode == MODE_18) ?
        quant_lane(sum_vector[ln*`QO_ACC_W +: `QO_ACC_W], scale_hi) : '0;
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  // holds last row between valid cycles
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      q_vector <= q_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= sum_valid;
    end
  end

  // mode is held by the controller across the whole tile
  a_mode88_upper_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (q_valid && (mode == MODE_88)) |-> (q_vector[`QO_Q_VEC_W-1:Q_HI_LSB] == '0)
  ) else $error("relu_scale_quant: upper lanes nonzero in MODE_88");

endmodule

// File: src/quant_output_top.sv
`timescale 1ns/1ps
`include "quant_defines.svh"

module quant_output_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  quant_pkg::quant_mode_e     mode,
  input  logic [`QO_SCALE_SET_W-1:0] scale_set,
  input  logic [`QO_BIAS_SET_W-1:0]  bias_set,
  input  logic [`QO_ROW_CNT_W-1:0]   row_count,
  input  logic                       acc_valid,
  input  logic [`QO_ACC_VEC_W-1:0]   acc_vector,
  output logic                       q_valid,
  output logic [`QO_Q_VEC_W-1:0]     q_vector,
  output logic                       busy,
  output logic                       done
);
  import quant_pkg::*;

  // counter handshake
  logic                       cnt_load;
  logic [`QO_ROW_CNT_W-1:0]   cnt_value;
  logic                       cnt_dec;
  logic                       cnt_zero;

  // latched tile settings
  quant_mode_e                mode_q;
  logic [`QO_SCALE_SET_W-1:0] scale_q;
  logic [`QO_BIAS_SET_W-1:0]  bias_q;

  // datapath between the two stages
  logic                       row_take;
  logic [`QO_ACC_VEC_W-1:0]   sum_vector;
  logic                       sum_valid;

  drain_ctrl_fsm drain_ctrl_fsm_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .mode      (mode),
    .scale_set (scale_set),
    .bias_set  (bias_set),
    .row_count (row_count),
    .acc_valid (acc_valid),
    .cnt_zero  (cnt_zero),
    .cnt_load  (cnt_load),
    .cnt_value (cnt_value),
    .cnt_dec   (cnt_dec),
    .row_take  (row_take),
    .mode_q    (mode_q),
    .scale_q   (scale_q),
    .bias_q    (bias_q),
    .busy      (busy),
    .done      (done)
  );

  drain_counter drain_counter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (cnt_load),
    .value     (cnt_value),
    .dec       (cnt_dec),
    .zero_next (cnt_zero)
  );

  bias_add_stage bias_add_stage_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .take       (row_take),
    .acc_vector (acc_vector),
    .bias_q     (bias_q),
    .sum_vector (sum_vector),
    .sum_valid  (sum_valid)
  );

  relu_scale_quant relu_scale_quant_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .sum_valid  (sum_valid),
    .sum_vector (sum_vector),
    .mode       (mode_q),
    .scale_q    (scale_q),
    .q_vector   (q_vector),
    .q_valid    (q_valid)
  );

endmodule

// File: verification/quant_output_tb.sv
`timescale 1ns/1ps
`include "quant_defines.svh"

module quant_output_tb;
  import quant_pkg::*;

  logic                       clk;
  logic                       rst_n;
  logic                       start;
  quant_mode_e                mode;
  logic [`QO_SCALE_SET_W-1:0] scale_set;
  logic [`QO_BIAS_SET_W-1:0]  bias_set;
  logic [`QO_ROW_CNT_W-1:0]   row_count;
  logic                       acc_valid;
  logic [`QO_ACC_VEC_W-1:0]   acc_vector;
  logic                       q_valid;
  logic [`QO_Q_VEC_W-1:0]     q_vector;
  logic                       busy;
  logic                       done;

  // edges recorded by the stimulus and delayed to line up with the outputs
  logic                       exp_take;
  logic                       exp_last;
  logic                       take_d1;
  logic                       take_d2;
  logic                       last_d1;
  logic                       last_d2;
  logic                       last_d3;
  logic                       seen_valid;
  logic [`QO_Q_VEC_W-1:0]     exp_head;
  logic [`QO_Q_VEC_W-1:0]     exp_q [$];

  int errors;
  int tests_run;
  int tests_failed;
  int cycles;
  int timeout_limit;

  quant_output_top quant_output_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .mode       (mode),
    .scale_set  (scale_set),
    .bias_set   (bias_set),
    .row_count  (row_count),
    .acc_valid  (acc_valid),
    .acc_vector (acc_vector),
    .q_valid    (q_valid),
    .q_vector   (q_vector),
    .busy       (busy),
    .done       (done)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (timeout_limit > 0 && cycles > timeout_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // expected output timing
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      take_d1    <= 1'b0;
      take_d2    <= 1'b0;
      last_d1    <= 1'b0;
      last_d2    <= 1'b0;
      last_d3    <= 1'b0;
      seen_valid <= 1'b0;
    end else begin
      take_d1 <= exp_take;
      take_d2 <= take_d1;
      last_d1 <= exp_take && exp_last;
      last_d2 <= last_d1;
      last_d3 <= last_d2;
      if (q_valid) begin
        seen_valid <= 1'b1;
      end
      // row reaches q_vector on the next edge
      if (take_d1) begin
        exp_head <= exp_q.pop_front();
      end
    end
  end

  a_q_value: assert property (
    @(posedge clk) disable iff (!rst_n)
    q_valid |-> (q_vector == exp_head)
  ) else begin
    errors++;
    $display("mismatch q_vector exp %h got %h", $sampled(exp_head), $sampled(q_vector));
  end

  // q_valid two cycles after each accepted row and never for ignored rows
  a_q_timing: assert property (
    @(posedge clk) disable iff (!rst_n)
    q_valid == take_d2
  ) else begin
    errors++;
    $display("mismatch q_valid exp %h got %h", $sampled(take_d2), $sampled(q_valid));
  end

  a_q_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (seen_valid && !q_valid) |-> $stable(q_vector)
  ) else begin
    errors++;
    $display("q_vector changed while q_valid was low");
  end

  a_done_timing: assert property (
    @(posedge clk) disable iff (!rst_n)
    done == last_d3
  ) else begin
    errors++;
    $display("mismatch done exp %h got %h", $sampled(last_d3), $sampled(done));
  end

  a_busy_drop: assert property (
    @(posedge clk) disable iff (!rst_n)
    done |=> !busy
  ) else begin
    errors++;
    $display("busy still high after done");
  end

  a_busy_rise: assert property (
    @(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy
  ) else begin
    errors++;
    $display("busy did not rise after an accepted start");
  end

  ////////////////////////////////////////////////////////////
  // reference model and stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [`QO_Q_VEC_W-1:0] expect_row(
    input logic [`QO_ACC_VEC_W-1:0]   acc,
    input quant_mode_e                m,
    input logic [`QO_SCALE_SET_W-1:0] sc,
    input logic [`QO_BIAS_SET_W-1:0]  bi
  );
    logic [`QO_Q_VEC_W-1:0]      row;
    logic signed [`QO_ACC_W-1:0] sum;
    longint                      val;
    int                          ln;
    int                          ch;
    row = '0;
    for (ln = 0; ln < `QO_LANES; ln++) begin
      ch = ln / `QO_LANES_PER_CH;
      // upper lanes stay zero in MODE_88
      if (!(ch == 1 && m == MODE_88)) begin
        sum = $signed(acc[ln*`QO_ACC_W +: `QO_ACC_W]) + $signed(bi[ch*`QO_BIAS_W +: `QO_BIAS_W]);
        val = sum;
        if (val < 0) begin
          val = 0;
        end else begin
          val = val >> sc[ch*`QO_SCALE_W +: `QO_SCALE_W];
        end
        if (val > (1 << `QO_Q_W) - 1) begin
          val = (1 << `QO_Q_W) - 1;
        end
        row[ln*`QO_Q_W +: `QO_Q_W] = val[`QO_Q_W-1:0];
      end
    end
    return row;
  endfunction

  // kind 0 in range, 1 negative after bias, 2 saturating, else raw random
  function automatic logic [`QO_ACC_VEC_W-1:0] make_acc(
    input int                         kind,
    input logic [`QO_SCALE_SET_W-1:0] sc,
    input logic [`QO_BIAS_SET_W-1:0]  bi
  );
    logic [`QO_ACC_VEC_W-1:0] vec;
    logic [`QO_ACC_W-1:0]     lane;
    logic [63:0]              wide;
    logic [`QO_SCALE_W-1:0]   s;
    int                       ln;
    int                       ch;
    for (ln = 0; ln < `QO_LANES; ln++) begin
      ch   = ln / `QO_LANES_PER_CH;
      s    = sc[ch*`QO_SCALE_W +: `QO_SCALE_W];
      wide = {$urandom, $urandom};
      case (kind)
        0: begin
          // target value shifted up plus low bits the shift drops
          lane = (`QO_ACC_W'($urandom_range(16, 255)) << s)
               + `QO_ACC_W'($urandom_range(0, (1 << s) - 1))
               - `QO_ACC_W'(bi[ch*`QO_BIAS_W +: `QO_BIAS_W]);
        end
        1: begin
          lane = (ln % 2) ? -`QO_ACC_W'($urandom_range(1, 1000000))
                          : `QO_ACC_W'($urandom_range(0, 999));
        end
        2: begin
          lane = (`QO_ACC_W'(wide[31:0]) << 6) | (`QO_ACC_W'(1) << 38);
        end
        default: begin
          lane = wide[`QO_ACC_W-1:0];
        end
      endcase
      vec[ln*`QO_ACC_W +: `QO_ACC_W] = lane;
    end
    return vec;
  endfunction

  function automatic int tile_cycles(input int rows, input int max_gap,
                                     input int idle, input int extra);
    return 2 * idle + rows * (1 + max_gap) + extra + 14;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic run_tile(
    input string       name,
    input quant_mode_e m,
    input int          kind,
    input int          rows,
    input int          max_gap,
    input int          idle_pulses,
    input int          extra_rows
  );
    logic [`QO_SCALE_SET_W-1:0] sc;
    logic [`QO_BIAS_SET_W-1:0]  bi;
    logic [`QO_ACC_VEC_W-1:0]   acc;
    int                         err_start;
    int                         waited;
    int                         ch;
    int                         r;
    err_start = errors;
    for (ch = 0; ch < `QO_CHANNELS; ch++) begin
      sc[ch*`QO_SCALE_W +: `QO_SCALE_W] = (kind == 2) ? `QO_SCALE_W'($urandom_range(0, 4))
                                                      : `QO_SCALE_W'($urandom_range(0, 12));
      case (kind)
        0: bi[ch*`QO_BIAS_W +: `QO_BIAS_W] = `QO_BIAS_W'($urandom_range(0, 15));
        1: bi[ch*`QO_BIAS_W +: `QO_BIAS_W] = -`QO_BIAS_W'($urandom_range(1000, 50000));
        2: bi[ch*`QO_BIAS_W +: `QO_BIAS_W] = `QO_BIAS_W'($urandom_range(0, 1000));
        default: bi[ch*`QO_BIAS_W +: `QO_BIAS_W] = $urandom;
      endcase
    end
    // stray rows while idle
    repeat (idle_pulses) begin
      acc_valid  = 1'b1;
      acc_vector = make_acc(3, sc, bi);
      next_cycle();
      acc_valid  = 1'b0;
      next_cycle();
    end
    start     = 1'b1;
    mode      = m;
    scale_set = sc;
    bias_set  = bi;
    row_count = `QO_ROW_CNT_W'(rows);
    next_cycle();
    // inputs scrambled so the DUT has to use its latched copy
    start     = 1'b0;
    mode      = quant_mode_e'($urandom_range(0, 1));
    scale_set = `QO_SCALE_SET_W'($urandom);
    bias_set  = {$urandom, $urandom};
    for (r = 0; r < rows; r++) begin
      repeat ($urandom_range(0, max_gap)) next_cycle();
      acc        = make_acc(kind, sc, bi);
      acc_valid  = 1'b1;
      acc_vector = acc;
      exp_take   = 1'b1;
      exp_last   = (r == rows - 1);
      exp_q.push_back(expect_row(acc, m, sc, bi));
      next_cycle();
      acc_valid  = 1'b0;
      exp_take   = 1'b0;
      exp_last   = 1'b0;
    end
    // rows past row_count land in ST_FLUSH
    repeat (extra_rows) begin
      acc_valid  = 1'b1;
      acc_vector = make_acc(3, sc, bi);
      next_cycle();
    end
    acc_valid = 1'b0;
    waited = 0;
    while (!done && waited < 10) begin
      next_cycle();
      waited++;
    end
    if (!done) begin
      errors++;
      $display("done did not arrive after the last row");
    end
    repeat (3) next_cycle();
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (errors == err_start) ? "ok" : "failed",
             errors - err_start);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(14));
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    cycles        = 0;
    timeout_limit = 2 * (6 + tile_cycles(6, 0, 0, 0) + tile_cycles(6, 0, 0, 0)
                           + tile_cycles(5, 1, 0, 0) + tile_cycles(4, 0, 0, 0)
                           + tile_cycles(8, 3, 3, 2) + tile_cycles(5, 2, 2, 2)) + 50;
    clk        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    mode       = MODE_88;
    scale_set  = '0;
    bias_set   = '0;
    row_count  = '0;
    acc_valid  = 1'b0;
    acc_vector = '0;
    exp_take   = 1'b0;
    exp_last   = 1'b0;
    repeat (4) next_cycle();
    rst_n = 1'b1;
    next_cycle();

    run_tile("positive_mode88", MODE_88, 0, 6, 0, 0, 0);
    run_tile("positive_mode18", MODE_18, 0, 6, 0, 0, 0);
    run_tile("negative_mode18", MODE_18, 1, 5, 1, 0, 0);
    run_tile("saturate_mode18", MODE_18, 2, 4, 0, 0, 0);
    run_tile("gaps_idle_extra_mode18", MODE_18, 3, 8, 3, 3, 2);
    run_tile("gaps_idle_extra_mode88", MODE_88, 3, 5, 2, 2, 2);

    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+src
src/quant_pkg.sv
src/drain_counter.sv
src/drain_ctrl_fsm.sv
src/bias_add_stage.sv
src/relu_scale_quant.sv
src/quant_output_top.sv
verification/quant_output_tb.sv
